/* verilog/zxuno_bus_pkg.sv */
`default_nettype none

////////////////////////////////////////
// CPU side of the register block
////////////////////////////////////////

package zxuno_bus_pkg;

   // Z80 I/O bus widths
   localparam int BUS_AW = 16;
   localparam int BUS_DW = 8;

   // Indirect register file ports
   // Address port, selects register number
   localparam logic [BUS_AW-1:0] IO_ADDR_PORT = 16'hFC3B;
   // Data port, reaches selected register
   localparam logic [BUS_AW-1:0] IO_DATA_PORT = 16'hFD3B;

   // Value seen for registers that do not exist
   localparam logic [BUS_DW-1:0] IDLE_READ = 8'hFF;

endpackage

`default_nettype wire

/* verilog/zxuno_reg_pkg.sv */
`default_nettype none

////////////////////////////////////////
// Register map
////////////////////////////////////////

package zxuno_reg_pkg;

   // Register numbers behind FD3B
   localparam logic [7:0] REG_MASTERCONF   = 8'h00;
   localparam logic [7:0] REG_MASTERMAPPER = 8'h01;
   localparam logic [7:0] REG_FLASHSPI     = 8'h02;
   localparam logic [7:0] REG_FLASHCS      = 8'h03;
   localparam logic [7:0] REG_SCANCODE     = 8'h04;

   // Master configuration bits
   // LOCK 0 0 TIMING ISSUE2 DISNMI ENDIV ENBOOT
   localparam int CFG_LOCK   = 7;
   localparam int CFG_TIMING = 4;
   localparam int CFG_ISSUE2 = 3;
   localparam int CFG_DISNMI = 2;
   localparam int CFG_ENDIV  = 1;
   localparam int CFG_ENBOOT = 0;

   // Boot ROM mapped in after reset
   localparam logic [7:0] CFG_RESET = 8'h01;

   // 16K bank number for the C000 window
   localparam int BANK_W = 5;

   // SPI clock half period, in system clocks
   localparam int SPI_DIV = 1;

endpackage

`default_nettype wire

/* verilog/zxuno_regsel.sv */
`timescale 1ns/1ns
`default_nettype none

module zxuno_regsel (
   input  wire                              clk,
   input  wire                              rst,
   input  wire [zxuno_bus_pkg::BUS_AW-1:0]  a,
   input  wire                              iorq_n,
   input  wire                              rd_n,
   input  wire                              wr_n,
   input  wire [zxuno_bus_pkg::BUS_DW-1:0]  din,
   input  wire [7:0]                        mst_rdata,
   input  wire [7:0]                        spi_rdata,
   input  wire [7:0]                        kbd_rdata,
   output logic [zxuno_bus_pkg::BUS_DW-1:0] dout,
   output logic                             oe_n,
   output logic [7:0]                       reg_addr,
   output wire                              wr_stb,
   output wire                              rd_done
);
   import zxuno_bus_pkg::*;
   import zxuno_reg_pkg::*;

   // Port decode
   logic sel_addr;
   logic sel_data;
   // Data port access, current and last clock
   logic data_wr;
   logic data_rd;
   logic data_wr_q;
   logic data_rd_q;

   assign sel_addr = !iorq_n && (a == IO_ADDR_PORT);
   assign sel_data = !iorq_n && (a == IO_DATA_PORT);
   assign data_wr  = sel_data && !wr_n;
   assign data_rd  = sel_data && !rd_n;

   ////////////////////////////////////////
   // Register number latch
   ////////////////////////////////////////

   // Stored at the first edge of the write, later cycles rewrite same value
   always_ff @(posedge clk) begin
      if (rst) begin
         reg_addr <= 8'h00;
      end else if (sel_addr && !wr_n) begin
         reg_addr <= din;
      end
   end

   ////////////////////////////////////////
   // Strobes
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         data_wr_q <= 1'b0;
         data_rd_q <= 1'b0;
      end else begin
         data_wr_q <= data_wr;
         data_rd_q <= data_rd;
      end
   end

   // Rising edge of write, one pulse per bus cycle however long
   assign wr_stb  = data_wr && !data_wr_q;
   // Falling edge of read, so side effects follow the read
   assign rd_done = data_rd_q && !data_rd;

   ////////////////////////////////////////
   // Read mux
   ////////////////////////////////////////

   always_comb begin
      dout = IDLE_READ;
      oe_n = 1'b1;
      if (sel_addr && !rd_n) begin
         // Read back selected register number
         dout = reg_addr;
         oe_n = 1'b0;
      end else if (data_rd) begin
         oe_n = 1'b0;
         case (reg_addr)
            REG_MASTERCONF, REG_MASTERMAPPER: dout = mst_rdata;
            REG_FLASHSPI, REG_FLASHCS:        dout = spi_rdata;
            REG_SCANCODE:                     dout = kbd_rdata;
            // Unimplemented numbers float high
            default:                          dout = IDLE_READ;
         endcase
      end
   end

   // A write pulse must never coincide with the end of a read
   a_no_stb_overlap: assert property (@(posedge clk) disable iff (rst)
      !(wr_stb && rd_done))
      else $error("wr_stb and rd_done high in the same cycle");

endmodule

`default_nettype wire

/* verilog/zxuno_master_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module zxuno_master_regs (
   input  wire                              clk,
   input  wire                              rst,
   input  wire [7:0]                        reg_addr,
   input  wire [7:0]                        din,
   input  wire                              wr_stb,
   output logic [7:0]                       mst_rdata,
   output wire                              cfg_timing,
   output wire                              cfg_issue2,
   output wire                              cfg_disnmi,
   output wire                              cfg_endiv,
   output wire                              cfg_enboot,
   output wire [zxuno_reg_pkg::BANK_W-1:0]  map_bank
);
   import zxuno_reg_pkg::*;

   // Register $00
   logic [7:0]        conf;
   // Register $01
   logic [BANK_W-1:0] bank;
   // Lock bit freezes both registers
   logic              locked;

   assign locked = conf[CFG_LOCK];

   ////////////////////////////////////////
   // Write side
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         conf <= CFG_RESET;
         bank <= '0;
      end else if (wr_stb && !locked) begin
         if (reg_addr == REG_MASTERCONF) begin
            conf <= din;
         end
         // Only low bits of the bank number exist
         if (reg_addr == REG_MASTERMAPPER) begin
            bank <= din[BANK_W-1:0];
         end
      end
   end

   // Machine controls
   assign cfg_timing = conf[CFG_TIMING];
   assign cfg_issue2 = conf[CFG_ISSUE2];
   assign cfg_disnmi = conf[CFG_DISNMI];
   assign cfg_endiv  = conf[CFG_ENDIV];
   assign cfg_enboot = conf[CFG_ENBOOT];
   assign map_bank   = bank;

   // Read side, upper bank bits return zero
   always_comb begin
      if (reg_addr == REG_MASTERMAPPER) begin
         mst_rdata = {{(8 - BANK_W){1'b0}}, bank};
      end else begin
         mst_rdata = conf;
      end
   end

endmodule

`default_nettype wire

/* verilog/zxuno_spi_port.sv */
`timescale 1ns/1ns
`default_nettype none

module zxuno_spi_port (
   input  wire        clk,
   input  wire        rst,
   input  wire [7:0]  reg_addr,
   input  wire [7:0]  din,
   input  wire        wr_stb,
   input  wire        flash_miso,
   output logic [7:0] spi_rdata,
   output logic       spi_busy,
   output wire        flash_cs_n,
   output logic       flash_sck,
   output wire        flash_mosi
);
   import zxuno_reg_pkg::*;

   // Clock divider
   logic [7:0] div_cnt;
   logic       tick;
   // Bits done in this byte
   logic [2:0] bit_cnt;
   // Out on MSB, in on LSB
   logic [7:0] shreg;
   // Register $03
   logic       cs_n;
   logic       start;

   // Writes while a byte is in flight are dropped
   assign start = wr_stb && (reg_addr == REG_FLASHSPI) && !spi_busy;
   assign tick  = (div_cnt == 8'(SPI_DIV - 1));

   ////////////////////////////////////////
   // Byte shifter, SPI mode 0
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         spi_busy  <= 1'b0;
         flash_sck <= 1'b0;
         div_cnt   <= '0;
         bit_cnt   <= '0;
      end else if (start) begin
         spi_busy  <= 1'b1;
         flash_sck <= 1'b0;
         div_cnt   <= '0;
         bit_cnt   <= '0;
      end else if (spi_busy) begin
         if (tick) begin
            div_cnt   <= '0;
            flash_sck <= !flash_sck;
            // Falling edge ends a bit
            if (flash_sck) begin
               bit_cnt <= bit_cnt + 3'd1;
               if (bit_cnt == 3'd7) begin
                  spi_busy <= 1'b0;
               end
            end
         end else begin
            div_cnt <= div_cnt + 8'd1;
         end
      end
   end

   // Load on start, shift as SCK falls, MISO stable while SCK high
   always_ff @(posedge clk) begin
      if (start) begin
         shreg <= din;
      end else if (spi_busy && tick && flash_sck) begin
         shreg <= {shreg[6:0], flash_miso};
      end
   end

   assign flash_mosi = shreg[7];

   // Chip select, low selects the flash
   always_ff @(posedge clk) begin
      if (rst) begin
         cs_n <= 1'b1;
      end else if (wr_stb && (reg_addr == REG_FLASHCS)) begin
         cs_n <= din[0];
      end
   end

   assign flash_cs_n = cs_n;

   // $02 gives last received byte
   always_comb begin
      if (reg_addr == REG_FLASHCS) begin
         spi_rdata = {7'b0, cs_n};
      end else begin
         spi_rdata = shreg;
      end
   end

   // While a byte is in flight the shifter only moves on SCK falls
   a_no_load_busy: assert property (@(posedge clk) disable iff (rst)
      (spi_busy && !(tick && flash_sck)) |=> (shreg == $past(shreg)))
      else $error("SPI shift register loaded during a transfer");

endmodule

`default_nettype wire

/* verilog/zxuno_kbd_port.sv */
`timescale 1ns/1ns
`default_nettype none

module zxuno_kbd_port (
   input  wire        clk,
   input  wire        rst,
   input  wire [7:0]  reg_addr,
   input  wire        rd_done,
   input  wire [7:0]  kbd_code,
   input  wire        kbd_valid,
   output wire [7:0]  kbd_rdata,
   output wire        kbd_ready
);
   import zxuno_reg_pkg::*;

   // Last scancode, held until CPU reads it
   logic [7:0] code;
   logic       full;

   // Keyboard stalls while a code waits
   assign kbd_ready = !full;

   always_ff @(posedge clk) begin
      if (rst) begin
         code <= 8'h00;
         full <= 1'b0;
      end else if (kbd_valid && kbd_ready) begin
         code <= kbd_code;
         full <= 1'b1;
      end else if (rd_done && (reg_addr == REG_SCANCODE)) begin
         // Read finished, room for the next one
         full <= 1'b0;
      end
   end

   assign kbd_rdata = code;

   // Stalled offer must be held unchanged
   a_code_stable: assert property (@(posedge clk) disable iff (rst)
      (kbd_valid && !kbd_ready) |=> (kbd_valid && $stable(kbd_code)))
      else $error("kbd_code changed while stalled");

endmodule

`default_nettype wire

/* verilog/zxuno_regs_top.sv */
`timescale 1ns/1ns
`default_nettype none

module zxuno_regs_top (
   input  wire                              clk,
   input  wire                              rst,
   // CPU I/O bus
   input  wire [zxuno_bus_pkg::BUS_AW-1:0]  a,
   input  wire                              iorq_n,
   input  wire                              rd_n,
   input  wire                              wr_n,
   input  wire [zxuno_bus_pkg::BUS_DW-1:0]  din,
   output wire [zxuno_bus_pkg::BUS_DW-1:0]  dout,
   output wire                              oe_n,
   // Machine controls
   output wire                              cfg_timing,
   output wire                              cfg_issue2,
   output wire                              cfg_disnmi,
   output wire                              cfg_endiv,
   output wire                              cfg_enboot,
   output wire [zxuno_reg_pkg::BANK_W-1:0]  map_bank,
   // SPI flash
   input  wire                              flash_miso,
   output wire                              spi_busy,
   output wire                              flash_cs_n,
   output wire                              flash_sck,
   output wire                              flash_mosi,
   // Keyboard
   input  wire [7:0]                        kbd_code,
   input  wire                              kbd_valid,
   output wire                              kbd_ready
);

   wire [7:0] reg_addr;
   wire       wr_stb;
   wire       rd_done;
   // Read data back to the mux
   wire [7:0] mst_rdata;
   wire [7:0] spi_rdata;
   wire [7:0] kbd_rdata;

   zxuno_regsel u_regsel (
      .clk(clk), .rst(rst), .a(a), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
      .din(din), .mst_rdata(mst_rdata), .spi_rdata(spi_rdata),
      .kbd_rdata(kbd_rdata), .dout(dout), .oe_n(oe_n), .reg_addr(reg_addr),
      .wr_stb(wr_stb), .rd_done(rd_done)
   );

   zxuno_master_regs u_master (
      .clk(clk), .rst(rst), .reg_addr(reg_addr), .din(din), .wr_stb(wr_stb),
      .mst_rdata(mst_rdata), .cfg_timing(cfg_timing), .cfg_issue2(cfg_issue2),
      .cfg_disnmi(cfg_disnmi), .cfg_endiv(cfg_endiv), .cfg_enboot(cfg_enboot),
      .map_bank(map_bank)
   );

   zxuno_spi_port u_spi (
      .clk(clk), .rst(rst), .reg_addr(reg_addr), .din(din), .wr_stb(wr_stb),
      .flash_miso(flash_miso), .spi_rdata(spi_rdata), .spi_busy(spi_busy),
      .flash_cs_n(flash_cs_n), .flash_sck(flash_sck), .flash_mosi(flash_mosi)
   );

   zxuno_kbd_port u_kbd (
      .clk(clk), .rst(rst), .reg_addr(reg_addr), .rd_done(rd_done),
      .kbd_code(kbd_code), .kbd_valid(kbd_valid), .kbd_rdata(kbd_rdata),
      .kbd_ready(kbd_ready)
   );

endmodule

`default_nettype wire

/* testbench/tb_zxuno_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_zxuno_checker (
   input  wire [7:0]                        dout,
   input  wire                              oe_n,
   input  wire                              cfg_timing,
   input  wire                              cfg_issue2,
   input  wire                              cfg_disnmi,
   input  wire                              cfg_endiv,
   input  wire                              cfg_enboot,
   input  wire [zxuno_reg_pkg::BANK_W-1:0]  map_bank,
   input  wire                              flash_cs_n,
   input  wire                              flash_sck,
   input  wire                              flash_mosi,
   input  wire                              kbd_valid,
   input  wire                              kbd_ready
);

   // Result counts read by the testbench top
   int         pass_cnt = 0;
   int         fail_cnt = 0;
   // Flash side monitor
   int         sck_rises = 0;
   int         rise_base = 0;
   logic [7:0] mosi_bits = 8'h00;

   ////////////////////////////////////////
   // Flash bus monitor
   ////////////////////////////////////////

   // Mode 0 keeps MOSI settled while SCK rises
   always @(posedge flash_sck) begin
      sck_rises <= sck_rises + 1;
      mosi_bits <= {mosi_bits[6:0], flash_mosi};
   end

   ////////////////////////////////////////
   // Result lines
   ////////////////////////////////////////

   task automatic log_pass(input string name);
      pass_cnt++;
      $display("ok            %s", name);
   endtask

   task automatic log_problem(input string name, input string what);
      fail_cnt++;
      $display("ERROR         %s: %s", name, what);
   endtask

   task automatic score(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (act === exp) begin
         log_pass(name);
      end else begin
         fail_cnt++;
         $display("CHECK FAILED  %s expected %02h actual %02h", name, exp, act);
      end
   endtask

   ////////////////////////////////////////
   // Checks, one per table row
   ////////////////////////////////////////

   // Bus must stay undriven during a write
   task automatic check_write(input string name);
      if (oe_n !== 1'b1) begin
         log_problem(name, "oe_n went low during a write cycle");
      end else begin
         log_pass(name);
      end
   endtask

   task automatic check_read(input string name, input logic [7:0] exp);
      if (oe_n !== 1'b0) begin
         log_problem(name, "oe_n stayed high during a read cycle");
      end else begin
         score(name, exp, dout);
      end
   endtask

   // Status byte {valid, ready}
   task automatic check_key(input string name, input logic [7:0] exp);
      score(name, exp, {6'b0, kbd_valid, kbd_ready});
   endtask

   // Control pins picked by sel
   // 00 gives {000, timing, issue2, disnmi, endiv, enboot}
   // 01 gives the bank and anything else the chip select
   task automatic check_ctrl(input string name, input logic [7:0] sel,
                             input logic [7:0] exp);
      logic [7:0] act;
      case (sel)
         8'h00:   act = {3'b000, cfg_timing, cfg_issue2, cfg_disnmi, cfg_endiv, cfg_enboot};
         8'h01:   act = 8'(map_bank);
         default: act = {7'b0000000, flash_cs_n};
      endcase
      score(name, exp, act);
   endtask

   // Start of a flash byte
   task automatic mark_flash();
      rise_base = sck_rises;
   endtask

   task automatic check_flash(input string name, input logic [7:0] exp);
      int rises;
      rises = sck_rises - rise_base;
      if (rises != 8) begin
         fail_cnt++;
         $display("CHECK FAILED  %s expected 8 sck edges actual %0d", name, rises);
      end else begin
         score(name, exp, mosi_bits);
      end
   endtask

   task automatic report_stuck(input string name);
      log_problem(name, "spi_busy stuck high, the flash transfer never ended");
   endtask

   task automatic report_counts();
      $display("Checks passed %0d, failed %0d", pass_cnt, fail_cnt);
   endtask

endmodule

`default_nettype wire

/* testbench/tb_zxuno_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_zxuno_regs;
   import zxuno_bus_pkg::*;
   import zxuno_reg_pkg::*;

   typedef enum int {K_WR, K_RD, K_KEY, K_XFER, K_CTRL} row_kind_t;

   logic              clk = 1'b0;
   logic              rst;
   // CPU bus
   logic [BUS_AW-1:0] a;
   logic              iorq_n;
   logic              rd_n;
   logic              wr_n;
   logic [BUS_DW-1:0] din;
   wire  [BUS_DW-1:0] dout;
   wire               oe_n;
   // Machine controls
   wire               cfg_timing;
   wire               cfg_issue2;
   wire               cfg_disnmi;
   wire               cfg_endiv;
   wire               cfg_enboot;
   wire  [BANK_W-1:0] map_bank;
   // Flash
   wire               flash_miso;
   wire               spi_busy;
   wire               flash_cs_n;
   wire               flash_sck;
   wire               flash_mosi;
   logic [7:0]        flash_byte;
   logic [7:0]        miso_sr = 8'hFF;
   logic              sck_q = 1'b0;
   // Keyboard
   logic [7:0]        kbd_code = 8'h00;
   logic              kbd_valid = 1'b0;
   wire               kbd_ready;
   logic [7:0]        key_q[$];

   // Stimulus table
   string             row_name[$];
   row_kind_t         row_kind[$];
   logic [15:0]       row_port[$];
   logic [7:0]        row_data[$];
   logic [7:0]        row_exp[$];
   int                seed = 32'h6e59;

   zxuno_regs_top UUT (
      .clk(clk), .rst(rst), .a(a), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
      .din(din), .dout(dout), .oe_n(oe_n), .cfg_timing(cfg_timing),
      .cfg_issue2(cfg_issue2), .cfg_disnmi(cfg_disnmi), .cfg_endiv(cfg_endiv),
      .cfg_enboot(cfg_enboot), .map_bank(map_bank), .flash_miso(flash_miso),
      .spi_busy(spi_busy), .flash_cs_n(flash_cs_n), .flash_sck(flash_sck),
      .flash_mosi(flash_mosi), .kbd_code(kbd_code), .kbd_valid(kbd_valid),
      .kbd_ready(kbd_ready)
   );

   tb_zxuno_checker CHK (
      .dout(dout), .oe_n(oe_n), .cfg_timing(cfg_timing), .cfg_issue2(cfg_issue2),
      .cfg_disnmi(cfg_disnmi), .cfg_endiv(cfg_endiv), .cfg_enboot(cfg_enboot),
      .map_bank(map_bank), .flash_cs_n(flash_cs_n), .flash_sck(flash_sck),
      .flash_mosi(flash_mosi), .kbd_valid(kbd_valid), .kbd_ready(kbd_ready)
   );

   initial begin
      forever #2 clk = !clk;
   end

   ////////////////////////////////////////
   // Device models
   ////////////////////////////////////////

   // Flash answers MSB first and moves on after each SCK fall
   assign flash_miso = miso_sr[7];
   always @(posedge clk) begin
      sck_q <= flash_sck;
      if (!spi_busy) begin
         miso_sr <= flash_byte;
      end else if (sck_q && !flash_sck) begin
         miso_sr <= {miso_sr[6:0], 1'b0};
      end
   end

   // Keyboard holds each code until taken
   always @(posedge clk) begin
      if (kbd_valid && kbd_ready) begin
         kbd_valid <= 1'b0;
      end else if (!kbd_valid && key_q.size() > 0) begin
         kbd_code  <= key_q.pop_front();
         kbd_valid <= 1'b1;
      end
   end

   ////////////////////////////////////////
   // Table
   ////////////////////////////////////////

   task automatic add_row(input string name, input row_kind_t kind, input logic [15:0] port,
                          input logic [7:0] data, input logic [7:0] exp);
      row_name.push_back(name);
      row_kind.push_back(kind);
      row_port.push_back(port);
      row_data.push_back(data);
      row_exp.push_back(exp);
   endtask

   task automatic build_table();
      logic [31:0] rnd;
      logic [7:0]  code0;
      logic [7:0]  code1;
      rnd   = $random(seed);
      code0 = rnd[7:0];
      // Two different codes so the order shows
      do begin
         rnd   = $random(seed);
         code1 = rnd[7:0];
      end while (code1 == code0);
      // Register number latch and an unknown number
      add_row("select 2a", K_WR, IO_ADDR_PORT, 8'h2A, 8'h00);
      add_row("addr readback", K_RD, IO_ADDR_PORT, 8'h00, 8'h2A);
      add_row("unimpl reg", K_RD, IO_DATA_PORT, 8'h00, 8'hFF);
      // Configuration and mapper
      add_row("select conf", K_WR, IO_ADDR_PORT, REG_MASTERCONF, 8'h00);
      add_row("conf reset", K_RD, IO_DATA_PORT, 8'h00, 8'h01);
      add_row("conf write", K_WR, IO_DATA_PORT, 8'h12, 8'h00);
      add_row("conf readback", K_RD, IO_DATA_PORT, 8'h00, 8'h12);
      add_row("select mapper", K_WR, IO_ADDR_PORT, REG_MASTERMAPPER, 8'h00);
      add_row("mapper write", K_WR, IO_DATA_PORT, 8'hE9, 8'h00);
      // Bank field is 5 bits wide
      add_row("mapper readback", K_RD, IO_DATA_PORT, 8'h00, 8'h09);
      // Control rows use data to pick the pin group
      add_row("conf pins", K_CTRL, 16'h0000, 8'h00, 8'h12);
      add_row("bank pins", K_CTRL, 16'h0000, 8'h01, 8'h09);
      add_row("select conf 2", K_WR, IO_ADDR_PORT, REG_MASTERCONF, 8'h00);
      add_row("lock write", K_WR, IO_DATA_PORT, 8'h80, 8'h00);
      add_row("conf write locked", K_WR, IO_DATA_PORT, 8'h03, 8'h00);
      add_row("conf held", K_RD, IO_DATA_PORT, 8'h00, 8'h80);
      add_row("select mapper 2", K_WR, IO_ADDR_PORT, REG_MASTERMAPPER, 8'h00);
      add_row("mapper write locked", K_WR, IO_DATA_PORT, 8'h1F, 8'h00);
      add_row("mapper held", K_RD, IO_DATA_PORT, 8'h00, 8'h09);
      add_row("conf pins locked", K_CTRL, 16'h0000, 8'h00, 8'h00);
      add_row("bank pins locked", K_CTRL, 16'h0000, 8'h01, 8'h09);
      // SPI flash rows send data on MOSI and expect exp back
      add_row("select cs", K_WR, IO_ADDR_PORT, REG_FLASHCS, 8'h00);
      add_row("cs pin idle", K_CTRL, 16'h0000, 8'h02, 8'h01);
      add_row("cs low", K_WR, IO_DATA_PORT, 8'h00, 8'h00);
      add_row("cs pin low", K_CTRL, 16'h0000, 8'h02, 8'h00);
      add_row("cs readback", K_RD, IO_DATA_PORT, 8'h00, 8'h00);
      add_row("select spi", K_WR, IO_ADDR_PORT, REG_FLASHSPI, 8'h00);
      add_row("spi send a5", K_XFER, IO_DATA_PORT, 8'hA5, 8'h3C);
      add_row("spi reply 3c", K_RD, IO_DATA_PORT, 8'h00, 8'h3C);
      add_row("spi send 5a", K_XFER, IO_DATA_PORT, 8'h5A, 8'hC3);
      add_row("spi reply c3", K_RD, IO_DATA_PORT, 8'h00, 8'hC3);
      // Keyboard rows expect {valid, ready}
      add_row("key taken", K_KEY, 16'h0000, code0, 8'h00);
      add_row("key stalled", K_KEY, 16'h0000, code1, 8'h02);
      add_row("select scancode", K_WR, IO_ADDR_PORT, REG_SCANCODE, 8'h00);
      add_row("scancode first", K_RD, IO_DATA_PORT, 8'h00, code0);
      add_row("scancode second", K_RD, IO_DATA_PORT, 8'h00, code1);
   endtask

   ////////////////////////////////////////
   // Bus cycles
   ////////////////////////////////////////

   // 3 active clocks checked on the last one and 2 idle
   task automatic bus_cycle(input logic wr, input int idx, input logic sample);
      @(posedge clk);
      a      <= row_port[idx];
      din    <= row_data[idx];
      iorq_n <= 1'b0;
      rd_n   <= wr;
      wr_n   <= !wr;
      repeat (2) @(posedge clk);
      @(negedge clk);
      if (sample && wr) begin
         CHK.check_write(row_name[idx]);
      end else if (sample) begin
         CHK.check_read(row_name[idx], row_exp[idx]);
      end
      @(posedge clk);
      iorq_n <= 1'b1;
      rd_n   <= 1'b1;
      wr_n   <= 1'b1;
      @(posedge clk);
   endtask

   // Bounded wait for spi_busy to drop
   task automatic finish_transfer(input int idx);
      int waited;
      waited = 0;
      @(negedge clk);
      while (spi_busy === 1'b1 && waited < 40) begin
         @(negedge clk);
         waited++;
      end
      if (spi_busy === 1'b1) begin
         CHK.report_stuck(row_name[idx]);
      end else begin
         CHK.check_flash(row_name[idx], row_data[idx]);
      end
   endtask

   task automatic run_row(input int idx);
      case (row_kind[idx])
         K_WR: bus_cycle(1'b1, idx, 1'b1);
         K_RD: bus_cycle(1'b0, idx, 1'b1);
         K_XFER: begin
            flash_byte <= row_exp[idx];
            CHK.mark_flash();
            bus_cycle(1'b1, idx, 1'b0);
            finish_transfer(idx);
         end
         K_KEY: begin
            @(negedge clk);
            key_q.push_back(row_data[idx]);
            repeat (3) @(posedge clk);
            @(negedge clk);
            CHK.check_key(row_name[idx], row_exp[idx]);
            @(posedge clk);
         end
         default: begin
            @(negedge clk);
            CHK.check_ctrl(row_name[idx], row_data[idx], row_exp[idx]);
            @(posedge clk);
         end
      endcase
   endtask

   ////////////////////////////////////////
   // Run control
   ////////////////////////////////////////

   initial begin
      rst        = 1'b1;
      a          = '0;
      iorq_n     = 1'b1;
      rd_n       = 1'b1;
      wr_n       = 1'b1;
      din        = '0;
      flash_byte = 8'hFF;
      build_table();
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < row_name.size(); i++) begin
         run_row(i);
      end
      CHK.report_counts();
      if (CHK.fail_cnt == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // Watchdog allows 40 clocks per row plus margin
   initial begin
      #1;
      repeat (row_name.size() * 40 + 100) @(posedge clk);
      $display("Watchdog expired before all rows were run");
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

/* sim.f */
verilog/zxuno_bus_pkg.sv
verilog/zxuno_reg_pkg.sv
verilog/zxuno_regsel.sv
verilog/zxuno_master_regs.sv
verilog/zxuno_spi_port.sv
verilog/zxuno_kbd_port.sv
verilog/zxuno_regs_top.sv
testbench/tb_zxuno_checker.sv
testbench/tb_zxuno_regs.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the register block testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_zxuno_regs

# Simulator status alone is not trusted, the output decides
out=$(./obj_dir/Vtb_zxuno_regs) || true
echo "$out"
echo "$out" | grep -q "Test completed successfully"
